// File: src.f
hdl/dcache_pkg.sv
hdl/way_store.sv
hdl/beat_counter.sv
hdl/miss_fsm.sv
hdl/line_datapath.sv
hdl/dcache_top.sv
bench/clock_gen.sv
bench/dcache_checker.sv
bench/dcache_properties.sv
bench/tb_top.sv

// File: run.sh
#!/usr/bin/env bash
# build the data cache testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_top -f src.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

output=$(./obj_dir/Vtb_top)
run_status=$?
echo "$output"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if echo "$output" | grep -qx "Simulation completed successfully"; then
    exit 0
fi
exit 1

// File: bench/tb_top.sv
/*
 * data cache testbench
 * table driven processor requests, a slow memory model with random
 * latency, the checker and a cycle limit
 */

`timescale 1ns/1ps

module tb_top;

    import dcache_pkg::*;

    localparam int   NUM_SETS    = 4;
    localparam int   NUM_ENTRIES = 18;
    localparam int   CYCLE_LIMIT = NUM_ENTRIES * 40 + 100;
    localparam int   DRIVE_NS    = 1;
    localparam logic LOAD        = 1'b0;
    localparam logic STORE       = 1'b1;

    typedef struct packed {
        logic        write;
        logic [15:0] addr;
        word_t       data;
        byte_mask_t  mask;
        logic        fill;
        logic        wb;
    } stim_t;

    logic     clock;
    logic     reset;
    logic     cpu_req;
    cpu_req_t cpu_cmd;
    logic     cpu_ack;
    word_t    cpu_rdata;
    logic     mem_req;
    mem_cmd_t mem_cmd;
    logic     mem_ack;
    word_t    mem_rdata;
    int       entry_idx;
    logic     exp_fill;
    logic     exp_wb;
    logic     run_done;
    int       errors;
    int       entries_done;
    int       cycle_count = 0;
    stim_t    stim [NUM_ENTRIES];
    word_t    mem_words [16384];

    clock_gen clock_gen_i (
        .clock (clock),
        .reset (reset)
    );

    dcache_top #(
        .NUM_SETS (NUM_SETS)
    ) dut_i (
        .clock     (clock),
        .reset     (reset),
        .cpu_req   (cpu_req),
        .cpu_cmd   (cpu_cmd),
        .cpu_ack   (cpu_ack),
        .cpu_rdata (cpu_rdata),
        .mem_req   (mem_req),
        .mem_cmd   (mem_cmd),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    dcache_checker check_i (
        .clock        (clock),
        .reset        (reset),
        .cpu_req      (cpu_req),
        .cpu_cmd      (cpu_cmd),
        .cpu_ack      (cpu_ack),
        .cpu_rdata    (cpu_rdata),
        .mem_req      (mem_req),
        .mem_cmd      (mem_cmd),
        .mem_ack      (mem_ack),
        .entry_idx    (entry_idx),
        .exp_fill     (exp_fill),
        .exp_wb       (exp_wb),
        .run_done     (run_done),
        .errors       (errors),
        .entries_done (entries_done)
    );

    //////////////////////////////////////////////////
    // stimulus table
    //////////////////////////////////////////////////

    task automatic load_stimulus();
        // first fill of set 1 then hits and a partial store
        stim[0]  = '{LOAD,  16'h0008, 32'h0000_0000, 4'b0000, 1'b1, 1'b0};
        stim[1]  = '{LOAD,  16'h000C, 32'h0000_0000, 4'b0000, 1'b0, 1'b0};
        stim[2]  = '{LOAD,  16'h0008, 32'h0000_0000, 4'b0000, 1'b0, 1'b0};
        stim[3]  = '{STORE, 16'h0008, 32'hAABB_CCDD, 4'b0101, 1'b0, 1'b0};
        stim[4]  = '{LOAD,  16'h0008, 32'h0000_0000, 4'b0000, 1'b0, 1'b0};
        // LRU eviction in set 0 with A B A C then A and B again
        stim[5]  = '{LOAD,  16'h0000, 32'h0000_0000, 4'b0000, 1'b1, 1'b0};
        stim[6]  = '{LOAD,  16'h0020, 32'h0000_0000, 4'b0000, 1'b1, 1'b0};
        stim[7]  = '{LOAD,  16'h0004, 32'h0000_0000, 4'b0000, 1'b0, 1'b0};
        stim[8]  = '{LOAD,  16'h0040, 32'h0000_0000, 4'b0000, 1'b1, 1'b0};
        stim[9]  = '{LOAD,  16'h0000, 32'h0000_0000, 4'b0000, 1'b0, 1'b0};
        stim[10] = '{LOAD,  16'h0024, 32'h0000_0000, 4'b0000, 1'b1, 1'b0};
        // dirty line in set 2 evicted with two write-backs
        stim[11] = '{STORE, 16'h0010, 32'h1122_3344, 4'b1111, 1'b1, 1'b0};
        stim[12] = '{STORE, 16'h0014, 32'h5566_7788, 4'b0011, 1'b0, 1'b0};
        stim[13] = '{LOAD,  16'h0030, 32'h0000_0000, 4'b0000, 1'b1, 1'b0};
        stim[14] = '{LOAD,  16'h0050, 32'h0000_0000, 4'b0000, 1'b1, 1'b1};
        stim[15] = '{LOAD,  16'h0014, 32'h0000_0000, 4'b0000, 1'b1, 1'b0};
        // single byte store miss in set 3
        stim[16] = '{STORE, 16'h0018, 32'hDEAD_BEEF, 4'b1000, 1'b1, 1'b0};
        stim[17] = '{LOAD,  16'h0018, 32'h0000_0000, 4'b0000, 1'b0, 1'b0};
    endtask

    task automatic run_entry(input int idx);
        cpu_cmd.write = stim[idx].write;
        cpu_cmd.addr  = stim[idx].addr;
        cpu_cmd.wdata = stim[idx].data;
        cpu_cmd.mask  = stim[idx].mask;
        entry_idx     = idx;
        exp_fill      = stim[idx].fill;
        exp_wb        = stim[idx].wb;
        cpu_req       = 1'b1;
        do begin
            @(posedge clock);
            #(DRIVE_NS);
        end while (!cpu_ack);
        cpu_req = 1'b0;
        do begin
            @(posedge clock);
            #(DRIVE_NS);
        end while (cpu_ack);
    endtask

    initial begin : driver
        cpu_req   = 1'b0;
        cpu_cmd   = '0;
        entry_idx = 0;
        exp_fill  = 1'b0;
        exp_wb    = 1'b0;
        run_done  = 1'b0;
        load_stimulus();
        @(negedge reset);
        @(posedge clock);
        #(DRIVE_NS);
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            run_entry(i);
        end
        run_done = 1'b1;
        #(DRIVE_NS);
        if (errors == 0 && entries_done == NUM_ENTRIES) begin
            $display("Simulation completed successfully");
        end else begin
            if (entries_done != NUM_ENTRIES) begin
                $display("only %0d of %0d entries were checked", entries_done, NUM_ENTRIES);
            end
            $display("Simulation failed");
        end
        $finish;
    end

    //////////////////////////////////////////////////
    // memory model
    //////////////////////////////////////////////////

    initial begin : memory_model
        logic [13:0] widx;
        logic [15:0] byte_addr;
        int          delay;
        void'($urandom(6));
        mem_ack   = 1'b0;
        mem_rdata = '0;
        for (int i = 0; i < 16384; i++) begin
            widx = 14'(i);
            mem_words[widx] = 32'hC0DE0000 ^ {18'h0, widx};
        end
        forever begin
            @(posedge clock);
            #(DRIVE_NS);
            if (mem_req && !mem_ack) begin
                delay = 2 + int'($urandom % 4);
                repeat (delay) @(posedge clock);
                #(DRIVE_NS);
                byte_addr = mem_cmd.addr;
                widx      = byte_addr[15:2];
                if (mem_cmd.write) begin
                    mem_words[widx] = mem_cmd.wdata;
                end else begin
                    mem_rdata = mem_words[widx];
                end
                mem_ack = 1'b1;
                // ack stays up until the request drops
                do begin
                    @(posedge clock);
                    #(DRIVE_NS);
                end while (mem_req);
                mem_ack = 1'b0;
            end
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, entry %0d never finished", cycle_count, entry_idx);
            $display("Simulation failed");
            $finish;
        end
    end

endmodule

// File: bench/dcache_properties.sv
/*
 * handshake assertions for the data cache
 * processor and memory req/ack rules
 */

`timescale 1ns/1ps

module dcache_properties (
    input logic                 clock,
    input logic                 reset,
    input logic                 cpu_req,
    input logic                 cpu_ack,
    input logic                 mem_req,
    input logic                 mem_ack,
    input dcache_pkg::mem_cmd_t mem_cmd
);

    // ack only answers a pending request
    ack_needs_req: assert property (@(posedge clock) disable iff (reset)
        $rose(cpu_ack) |-> $past(cpu_req))
        else $error("cpu_ack rose with no cpu_req");

    mem_cmd_stable: assert property (@(posedge clock) disable iff (reset)
        mem_req && $past(mem_req) |-> mem_cmd == $past(mem_cmd))
        else $error("mem_cmd changed while mem_req was high");

    mem_req_held: assert property (@(posedge clock) disable iff (reset)
        mem_req && !mem_ack |=> mem_req)
        else $error("mem_req dropped before mem_ack");

endmodule

bind dcache_top dcache_properties dcache_properties_i (
    .clock   (clock),
    .reset   (reset),
    .cpu_req (cpu_req),
    .cpu_ack (cpu_ack),
    .mem_req (mem_req),
    .mem_ack (mem_ack),
    .mem_cmd (mem_cmd)
);

// File: bench/dcache_checker.sv
/*
 * data cache checker
 * follows each processor request, counts memory transfers, compares
 * loads and write-backs with a shadow byte memory, prints results
 */

`timescale 1ns/1ps

module dcache_checker (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 cpu_req,
    input  dcache_pkg::cpu_req_t cpu_cmd,
    input  logic                 cpu_ack,
    input  dcache_pkg::word_t    cpu_rdata,
    input  logic                 mem_req,
    input  dcache_pkg::mem_cmd_t mem_cmd,
    input  logic                 mem_ack,
    input  int                   entry_idx,
    input  logic                 exp_fill,
    input  logic                 exp_wb,
    input  logic                 run_done,
    output int                   errors,
    output int                   entries_done
);

    import dcache_pkg::*;

    logic [7:0] shadow [65536];
    cpu_req_t   req_q;
    logic       active;
    logic       ack_q;
    logic       reset_q;
    logic       fill_q;
    logic       wb_q;
    int         idx_q;
    int         reads;
    int         writes;
    int         cycles;
    int         entry_errors;
    int         passed;

    // memory starts as word address xor a fixed pattern
    initial begin : shadow_init
        logic [15:0] base;
        word_t       w;
        for (int a = 0; a < 65536; a += 4) begin
            base = 16'(a);
            w = 32'hC0DE0000 ^ {18'h0, base[15:2]};
            shadow[base]         = w[7:0];
            shadow[base + 16'd1] = w[15:8];
            shadow[base + 16'd2] = w[23:16];
            shadow[base + 16'd3] = w[31:24];
        end
    end

    function automatic word_t shadow_word(input logic [15:0] addr);
        logic [15:0] base;
        base = {addr[15:2], 2'b00};
        return {shadow[base + 16'd3], shadow[base + 16'd2], shadow[base + 16'd1], shadow[base]};
    endfunction

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("** Error: %s entry %0d got 0x%08h expected 0x%08h",
                     name, idx_q, got, expected);
            errors++;
            entry_errors++;
        end
    endtask

    task automatic report_problem(input string text);
        $display("entry %0d: %s", idx_q, text);
        errors++;
        entry_errors++;
    endtask

    //////////////////////////////////////////////////
    // memory transfers of one miss
    //////////////////////////////////////////////////

    task automatic record_transfer();
        logic [15:0] addr;
        logic [15:0] req_addr;
        addr     = mem_cmd.addr;
        req_addr = req_q.addr;
        if (mem_cmd.write) begin
            writes++;
            if (reads != 0) begin
                report_problem("write-back transfer after the fill had started");
            end
            check_equal("mem_cmd.addr set", {30'h0, addr[4:3]}, {30'h0, req_addr[4:3]});
            check_equal("mem_cmd.wdata", mem_cmd.wdata, shadow_word(addr));
        end else begin
            reads++;
            // fill reads stay inside the requested line
            check_equal("mem_cmd.addr line", {16'h0, addr[15:3], 3'b000},
                        {16'h0, req_addr[15:3], 3'b000});
        end
    endtask

    task automatic apply_store(input logic [15:0] addr);
        for (int b = 0; b < 4; b++) begin
            if (req_q.mask[b]) begin
                shadow[{addr[15:2], 2'(b)}] = req_q.wdata[8*b +: 8];
            end
        end
    endtask

    task automatic finish_entry();
        logic [15:0] req_addr;
        string       kind;
        string       verdict;
        req_addr = req_q.addr;
        check_equal("memory reads", reads, fill_q ? 32'd2 : 32'd0);
        check_equal("memory writes", writes, wb_q ? 32'd2 : 32'd0);
        if (!fill_q && cycles != 2) begin
            report_problem($sformatf("hit answered after %0d cycles instead of 2", cycles));
        end
        if (req_q.write) begin
            apply_store(req_addr);
        end else begin
            check_equal("cpu_rdata", cpu_rdata, shadow_word(req_addr));
        end
        kind    = req_q.write ? "store" : "load ";
        verdict = (entry_errors == 0) ? "ok" : "mismatch";
        $display("entry %2d %s addr 0x%04h reads %0d writes %0d : %s",
                 idx_q, kind, req_addr, reads, writes, verdict);
        if (entry_errors == 0) begin
            passed++;
        end
        entries_done++;
        active = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // sampling, mid-cycle
    //////////////////////////////////////////////////

    always @(negedge clock) begin
        if (reset) begin
            active       = 1'b0;
            errors       = 0;
            entries_done = 0;
            passed       = 0;
        end else begin
            if (reset_q) begin
                check_equal("cpu_ack after reset", {31'h0, cpu_ack}, 32'h0);
                check_equal("mem_req after reset", {31'h0, mem_req}, 32'h0);
            end
            if (active) begin
                cycles++;
            end
            if (!active && cpu_req && !cpu_ack) begin
                active       = 1'b1;
                req_q        = cpu_cmd;
                idx_q        = entry_idx;
                fill_q       = exp_fill;
                wb_q         = exp_wb;
                reads        = 0;
                writes       = 0;
                cycles       = 0;
                entry_errors = 0;
            end
            if (mem_req && mem_ack) begin
                if (active) begin
                    record_transfer();
                end else begin
                    report_problem("memory transfer with no request pending");
                end
            end
            if (active && cpu_ack && !ack_q) begin
                finish_entry();
            end
        end
        reset_q = reset;
        ack_q   = cpu_ack;
    end

    always @(posedge run_done) begin
        $display("checked %0d entries, %0d passed, %0d failed, %0d errors",
                 entries_done, passed, entries_done - passed, errors);
    end

endmodule

// File: bench/clock_gen.sv
/*
 * testbench clock and reset
 * 8 ns clock, reset held high over the first three rising edges
 */

`timescale 1ns/1ps

module clock_gen (
    output logic clock,
    output logic reset
);

    localparam int HALF_PERIOD_NS = 4;

    initial begin
        clock = 1'b0;
        forever #(HALF_PERIOD_NS) clock = ~clock;
    end

    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clock);
        #1;
        reset = 1'b0;
    end

endmodule

// File: hdl/dcache_top.sv
/*
 * 2-way set-associative write-back data cache
 * controller, beat counter, datapath and tag/data arrays
 */

`timescale 1ns/1ps

module dcache_top #(
    parameter int NUM_SETS = dcache_pkg::DEFAULT_NUM_SETS
) (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 cpu_req,
    input  dcache_pkg::cpu_req_t cpu_cmd,
    output logic                 cpu_ack,
    output dcache_pkg::word_t    cpu_rdata,
    output logic                 mem_req,
    output dcache_pkg::mem_cmd_t mem_cmd,
    input  logic                 mem_ack,
    input  dcache_pkg::word_t    mem_rdata
);

    import dcache_pkg::*;

    localparam int SET_W = $clog2(NUM_SETS);

    // one array row carries both ways of a set
    typedef meta_t [1:0] meta_pair_t;
    typedef line_t [1:0] line_pair_t;

    line_ctrl_t       ctrl;
    line_status_t     status;
    logic             beat;
    logic             beat_last;
    logic             beat_step;
    logic             mem_write;
    mem_cmd_t         dp_cmd;
    logic [SET_W-1:0] tag_addr;
    logic [SET_W-1:0] data_addr;
    logic             tag_we;
    logic             data_we;
    meta_pair_t       tag_wdata;
    meta_pair_t       tag_rdata;
    line_pair_t       data_wdata;
    line_pair_t       data_rdata;

    miss_fsm miss_fsm_i (
        .clock     (clock),
        .reset     (reset),
        .cpu_req   (cpu_req),
        .mem_ack   (mem_ack),
        .cpu_ack   (cpu_ack),
        .mem_req   (mem_req),
        .status    (status),
        .ctrl      (ctrl),
        .beat_last (beat_last),
        .beat_step (beat_step),
        .mem_write (mem_write)
    );

    beat_counter beat_counter_i (
        .clock (clock),
        .reset (reset),
        .step  (beat_step),
        .beat  (beat),
        .last  (beat_last)
    );

    line_datapath #(
        .NUM_SETS (NUM_SETS)
    ) line_datapath_i (
        .clock             (clock),
        .reset             (reset),
        .cpu_cmd           (cpu_cmd),
        .ctrl              (ctrl),
        .status            (status),
        .beat              (beat),
        .mem_rdata         (mem_rdata),
        .mem_cmd_addr_word (dp_cmd),
        .cpu_rdata         (cpu_rdata),
        .tag_addr          (tag_addr),
        .tag_we            (tag_we),
        .tag_wdata         (tag_wdata),
        .tag_rdata         (tag_rdata),
        .data_addr         (data_addr),
        .data_we           (data_we),
        .data_wdata        (data_wdata),
        .data_rdata        (data_rdata)
    );

    way_store #(
        .entry_t (meta_pair_t),
        .DEPTH   (NUM_SETS)
    ) tag_store (
        .clock (clock),
        .raddr (tag_addr),
        .waddr (tag_addr),
        .rdata (tag_rdata),
        .we    (tag_we),
        .wdata (tag_wdata)
    );

    way_store #(
        .entry_t (line_pair_t),
        .DEPTH   (NUM_SETS)
    ) data_store (
        .clock (clock),
        .raddr (data_addr),
        .waddr (data_addr),
        .rdata (data_rdata),
        .we    (data_we),
        .wdata (data_wdata)
    );

    // transfer direction comes from the controller
    assign mem_cmd = '{write: mem_write, addr: dp_cmd.addr, wdata: dp_cmd.wdata};

endmodule

// File: hdl/line_datapath.sv
/*
 * cache line datapath
 * tag compare, LRU and valid bits, victim choice, store merge,
 * fill assembly, load word select and write-back address
 */

`timescale 1ns/1ps

module line_datapath #(
    parameter int NUM_SETS = dcache_pkg::DEFAULT_NUM_SETS
) (
    input  logic                          clock,
    input  logic                          reset,
    input  dcache_pkg::cpu_req_t          cpu_cmd,
    input  dcache_pkg::line_ctrl_t        ctrl,
    output dcache_pkg::line_status_t      status,
    input  logic                          beat,
    input  dcache_pkg::word_t             mem_rdata,
    output dcache_pkg::mem_cmd_t          mem_cmd_addr_word,
    output dcache_pkg::word_t             cpu_rdata,
    output logic [$clog2(NUM_SETS)-1:0]   tag_addr,
    output logic                          tag_we,
    output dcache_pkg::meta_t [1:0]       tag_wdata,
    input  dcache_pkg::meta_t [1:0]       tag_rdata,
    output logic [$clog2(NUM_SETS)-1:0]   data_addr,
    output logic                          data_we,
    output dcache_pkg::line_t [1:0]       data_wdata,
    input  dcache_pkg::line_t [1:0]       data_rdata
);

    import dcache_pkg::*;

    localparam int SET_W = $clog2(NUM_SETS);

    logic [SET_W-1:0]          set_idx;
    logic [1:0]                way_hit;
    logic                      hit_way;
    logic                      victim;
    logic                      store_en;
    logic [NUM_SETS-1:0][1:0]  valid_q;
    logic [NUM_SETS-1:0]       lru_q;
    logic                      writing_back;
    logic                      beat_q;
    line_t                     fill_line;
    word_t                     merged_word;

    // both arrays always read the requested set
    assign set_idx   = SET_W'(cpu_cmd.addr.set_idx);
    assign tag_addr  = set_idx;
    assign data_addr = set_idx;

    //////////////////////////////////////////////////
    // lookup
    //////////////////////////////////////////////////

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = valid_q[set_idx][w] && tag_rdata[w].valid
                         && tag_rdata[w].tag == cpu_cmd.addr.tag;
        end
    end

    assign hit_way = way_hit[1];
    // lru bit names the least recently used way
    assign victim  = lru_q[set_idx];

    assign status.hit          = |way_hit;
    assign status.victim_dirty = valid_q[set_idx][victim] && tag_rdata[victim].dirty;

    assign cpu_rdata = data_rdata[hit_way][cpu_cmd.addr.word_idx];

    //////////////////////////////////////////////////
    // line writes
    //////////////////////////////////////////////////

    always_comb begin
        merged_word = data_rdata[hit_way][cpu_cmd.addr.word_idx];
        for (int b = 0; b < 4; b++) begin
            if (cpu_cmd.mask[b]) begin
                merged_word[8*b +: 8] = cpu_cmd.wdata[8*b +: 8];
            end
        end
    end

    assign store_en = ctrl.store_write && cpu_cmd.write;
    assign tag_we   = store_en || ctrl.line_write;
    assign data_we  = store_en || ctrl.line_write;

    always_comb begin
        tag_wdata  = tag_rdata;
        data_wdata = data_rdata;
        if (ctrl.line_write) begin
            // filled line comes in clean
            tag_wdata[victim]  = '{valid: 1'b1, dirty: 1'b0, tag: cpu_cmd.addr.tag};
            data_wdata[victim] = fill_line;
        end else begin
            tag_wdata[hit_way].dirty = 1'b1;
            data_wdata[hit_way][cpu_cmd.addr.word_idx] = merged_word;
        end
    end

    //////////////////////////////////////////////////
    // memory transfer address and data
    //////////////////////////////////////////////////

    always_comb begin
        mem_cmd_addr_word.write         = writing_back;
        mem_cmd_addr_word.addr.tag      = writing_back ? tag_rdata[victim].tag
                                                       : cpu_cmd.addr.tag;
        mem_cmd_addr_word.addr.set_idx  = cpu_cmd.addr.set_idx;
        mem_cmd_addr_word.addr.word_idx = beat;
        mem_cmd_addr_word.addr.byte_off = 2'b00;
        mem_cmd_addr_word.wdata         = data_rdata[victim][beat];
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q      <= '0;
            lru_q        <= '0;
            writing_back <= 1'b0;
            beat_q       <= 1'b0;
        end else begin
            beat_q <= beat;
            if (ctrl.line_write) begin
                valid_q[set_idx][victim] <= 1'b1;
            end
            if (ctrl.touch) begin
                lru_q[set_idx] <= ~hit_way;
            end
            // write-back ends when the beat wraps
            if (ctrl.lookup) begin
                writing_back <= !status.hit && status.victim_dirty;
            end else if (beat_q && !beat) begin
                writing_back <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (ctrl.fill_capture) begin
            fill_line[beat] <= mem_rdata;
        end
    end

endmodule

// File: hdl/miss_fsm.sv
/*
 * cache controller FSM
 * lookup, write-back, fill, line update and the req/ack handshakes
 * on the processor and memory sides
 */

`timescale 1ns/1ps

module miss_fsm (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     cpu_req,
    input  logic                     mem_ack,
    output logic                     cpu_ack,
    output logic                     mem_req,
    input  dcache_pkg::line_status_t status,
    output dcache_pkg::line_ctrl_t   ctrl,
    input  logic                     beat_last,
    output logic                     beat_step,
    output logic                     mem_write
);

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITE_BACK,
        FILL,
        UPDATE,
        RESPOND,
        RELEASE
    } state_t;

    state_t state;
    state_t next_state;
    logic   drop_wait;
    logic   ack_seen;
    logic   xfer_next;

    assign ack_seen  = mem_req && mem_ack;
    assign xfer_next = next_state == WRITE_BACK || next_state == FILL;

    //////////////////////////////////////////////////
    // next state
    //////////////////////////////////////////////////

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (cpu_req) next_state = LOOKUP;
            end
            LOOKUP: begin
                if (status.hit) begin
                    next_state = RESPOND;
                end else if (status.victim_dirty) begin
                    next_state = WRITE_BACK;
                end else begin
                    next_state = FILL;
                end
            end
            WRITE_BACK: begin
                if (ack_seen && beat_last) next_state = FILL;
            end
            FILL: begin
                if (ack_seen && beat_last) next_state = UPDATE;
            end
            // replay the lookup, now a hit
            UPDATE:  next_state = LOOKUP;
            RESPOND: begin
                if (!cpu_req) next_state = RELEASE;
            end
            // ack is already low, so a new request is taken at once
            RELEASE: next_state = cpu_req ? LOOKUP : IDLE;
            default: next_state = IDLE;
        endcase
    end

    //////////////////////////////////////////////////
    // state and memory handshake
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= IDLE;
            mem_req   <= 1'b0;
            drop_wait <= 1'b0;
        end else begin
            state <= next_state;
            if (ack_seen) begin
                mem_req   <= 1'b0;
                drop_wait <= 1'b1;
            end else if (drop_wait) begin
                // next transfer starts once the ack has fallen
                if (!mem_ack) begin
                    drop_wait <= 1'b0;
                    mem_req   <= xfer_next;
                end
            end else if (!mem_req) begin
                mem_req <= xfer_next;
            end
        end
    end

    assign cpu_ack   = state == RESPOND;
    assign mem_write = state == WRITE_BACK;
    assign beat_step = ack_seen;

    // datapath commands
    assign ctrl.lookup       = state == LOOKUP;
    assign ctrl.touch        = state == LOOKUP && status.hit;
    // only takes effect for stores
    assign ctrl.store_write  = state == LOOKUP && status.hit;
    assign ctrl.fill_capture = ack_seen && state == FILL;
    assign ctrl.line_write   = state == UPDATE;

endmodule

// File: hdl/beat_counter.sv
/*
 * beat counter
 * word index within a line during write-back and fill transfers
 */

`timescale 1ns/1ps

module beat_counter (
    input  logic clock,
    input  logic reset,
    input  logic step,
    output logic beat,
    output logic last
);

    import dcache_pkg::*;

    assign last = beat == 1'(WORDS_PER_LINE - 1);

    always_ff @(posedge clock) begin
        if (reset) begin
            beat <= 1'b0;
        end else if (step) begin
            // wrap after the final word
            beat <= last ? 1'b0 : beat + 1'b1;
        end
    end

endmodule

// File: hdl/way_store.sv
/*
 * way storage array
 * one row per set, registered read, write data forwarded to a
 * read of the same row in the same cycle
 */

`timescale 1ns/1ps

module way_store #(
    parameter type entry_t = logic [31:0],
    parameter int  DEPTH   = 4
) (
    input  logic                     clock,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    output entry_t                   rdata,
    input  logic                     we,
    input  entry_t                   wdata
);

    entry_t mem [DEPTH];

    always_ff @(posedge clock) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        // new row is visible on the very next cycle
        if (we && waddr == raddr) begin
            rdata <= wdata;
        end else begin
            rdata <= mem[raddr];
        end
    end

endmodule

// File: hdl/dcache_pkg.sv
/*
 * data cache shared types
 * address fields, word and line types, metadata, the processor and
 * memory request formats, and the controller/datapath command structs
 */

package dcache_pkg;

    localparam int DEFAULT_NUM_SETS = 4;
    localparam int WORDS_PER_LINE   = 2;

    // address split for the default geometry
    localparam int SET_BITS = $clog2(DEFAULT_NUM_SETS);
    localparam int TAG_BITS = 16 - SET_BITS - 3;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  byte_mask_t;

    // 16-bit byte address, high to low
    typedef struct packed {
        logic [TAG_BITS-1:0] tag;
        logic [SET_BITS-1:0] set_idx;
        logic                word_idx;
        logic [1:0]          byte_off;
    } addr_t;

    typedef word_t [WORDS_PER_LINE-1:0] line_t;

    // one way's tag entry
    typedef struct packed {
        logic                valid;
        logic                dirty;
        logic [TAG_BITS-1:0] tag;
    } meta_t;

    typedef struct packed {
        logic       write;
        addr_t      addr;
        word_t      wdata;
        byte_mask_t mask;
    } cpu_req_t;

    // one memory transfer, word aligned
    typedef struct packed {
        logic  write;
        addr_t addr;
        word_t wdata;
    } mem_cmd_t;

    typedef struct packed {
        logic lookup;
        logic store_write;
        logic fill_capture;
        logic line_write;
        logic touch;
    } line_ctrl_t;

    typedef struct packed {
        logic hit;
        logic victim_dirty;
    } line_status_t;

endpackage
